// ==== hw/cache_settings.svh ====
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// ========================================
// cache geometry
// ========================================

// byte address width of the cpu and memory ports
`define CACHE_ADDR_BITS 32

// words per line and number of lines
`define CACHE_LINE_WORDS 4
`define CACHE_LINES 16

// ========================================
// address split: tag | index | offset | byte
// ========================================

`define CACHE_OFFSET_BITS 2
`define CACHE_INDEX_BITS 4
// two low bits select the byte within a word
`define CACHE_TAG_BITS (`CACHE_ADDR_BITS - `CACHE_INDEX_BITS - `CACHE_OFFSET_BITS - 2)

`endif

// ==== hw/cache_types_pkg.sv ====
`include "cache_settings.svh"

package cache_types_pkg;

    // ========================================
    // widths with a meaning
    // ========================================

    typedef logic [31:0] word_t;
    typedef logic [`CACHE_ADDR_BITS-1:0] addr_t;
    typedef logic [`CACHE_TAG_BITS-1:0] tag_t;
    typedef logic [`CACHE_INDEX_BITS-1:0] index_t;
    typedef logic [`CACHE_OFFSET_BITS-1:0] offset_t;

    // bit 2 marks an unsigned load, bits 1:0 give the size
    typedef logic [2:0] access_size_t;

    localparam logic [1:0] SIZE_BYTE = 2'd0;
    localparam logic [1:0] SIZE_HALF = 2'd1;
    localparam logic [1:0] SIZE_WORD = 2'd2;

    // ========================================
    // miss handling fsm
    // ========================================

    typedef enum logic [2:0] {
        IDLE,
        PRE_BACK,
        BACK,
        FILL,
        WAIT
    } ctrl_state_t;

endpackage

// ==== hw/cache_bus_pkg.sv ====
package cache_bus_pkg;

    import cache_types_pkg::*;

    // ========================================
    // cpu load/store port
    // ========================================

    typedef struct packed {
        logic read;
        logic write;
        addr_t addr;
        access_size_t size;
        word_t wdata;
    } cpu_req_t;

    // ========================================
    // word-wide memory bus
    // ========================================

    // held stable while cs is high until ack
    typedef struct packed {
        logic cs;
        logic we;
        addr_t addr;
        word_t wdata;
    } mem_req_t;

    typedef struct packed {
        word_t rdata;
        logic ack;
    } mem_resp_t;

    // write command shared by the tag and data stores
    typedef struct packed {
        index_t index;
        offset_t offset;
        logic refill;
        logic edit;
        logic [3:0] be;
        word_t wdata;
        tag_t tag;
    } store_wr_t;

endpackage

// ==== hw/tag_store.sv ====
`include "cache_settings.svh"

module tag_store
    import cache_types_pkg::*;
    import cache_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    // lookup
    input  index_t    index_i,
    input  tag_t      tag_i,

    // update from the controller
    input  store_wr_t wr_i,

    output logic      valid_o,
    output logic      dirty_o,
    output tag_t      tag_o,
    output logic      hit_o
);

    // one status bit pair per line
    logic [`CACHE_LINES-1:0] valid_q;
    logic [`CACHE_LINES-1:0] dirty_q;

    tag_t tags_q [`CACHE_LINES];

    // ========================================
    // status bits
    // ========================================

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (wr_i.refill) begin
            // a line being filled is clean
            valid_q[wr_i.index] <= 1'b1;
            dirty_q[wr_i.index] <= 1'b0;
        end else if (wr_i.edit) begin
            dirty_q[wr_i.index] <= 1'b1;
        end
    end

    // ========================================
    // tag array
    // ========================================

    always_ff @(posedge clk) begin
        if (wr_i.refill) begin
            tags_q[wr_i.index] <= wr_i.tag;
        end
    end

    // combinational lookup
    assign valid_o = valid_q[index_i];
    assign dirty_o = dirty_q[index_i];
    assign tag_o   = tags_q[index_i];

    assign hit_o = valid_o && (tag_o == tag_i);

endmodule

// ==== hw/data_store.sv ====
`include "cache_settings.svh"

module data_store
    import cache_types_pkg::*;
    import cache_bus_pkg::*;
(
    input  logic      clk,

    // read address, shared with the tag store
    input  index_t    index_i,
    input  offset_t   offset_i,

    // write command
    input  store_wr_t wr_i,

    // addressed word, for loads and for write-back
    output word_t     rdata_o
);

    // ========================================
    // line storage
    // ========================================

    word_t lines_q [`CACHE_LINES][`CACHE_LINE_WORDS];

    word_t cur_word;
    word_t merged_word;
    word_t write_word;
    logic  write_en;

    // word under the write address
    assign cur_word = lines_q[wr_i.index][wr_i.offset];

    // ========================================
    // byte lane merge for partial stores
    // ========================================

    always_comb begin
        merged_word = cur_word;
        for (int b = 0; b < 4; b++) begin
            if (wr_i.be[b]) begin
                merged_word[b*8 +: 8] = wr_i.wdata[b*8 +: 8];
            end
        end
    end

    // refill replaces the word, a store edits lanes
    always_comb begin
        if (wr_i.refill) begin
            write_word = wr_i.wdata;
        end else begin
            write_word = merged_word;
        end
    end

    assign write_en = wr_i.refill || wr_i.edit;

    always_ff @(posedge clk) begin
        if (write_en) begin
            lines_q[wr_i.index][wr_i.offset] <= write_word;
        end
    end

    // ========================================
    // read port
    // ========================================

    assign rdata_o = lines_q[index_i][offset_i];

endmodule

// ==== hw/cache_ctrl.sv ====
`include "cache_settings.svh"

module cache_ctrl
    import cache_types_pkg::*;
    import cache_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    // cpu side
    input  cpu_req_t  cpu_req_i,

    // store status and data
    input  logic      hit_i,
    input  logic      valid_i,
    input  logic      dirty_i,
    input  tag_t      tag_i,
    input  word_t     word_i,

    // memory side
    input  mem_resp_t mem_resp_i,

    // store addressing and writes
    output index_t    index_o,
    output offset_t   offset_o,
    output tag_t      lookup_tag_o,
    output store_wr_t wr_o,

    output mem_req_t  mem_req_o,
    output word_t     rdata_o,
    output logic      stall_o
);

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    offset_t     count_q;
    offset_t     count_d;

    tag_t        req_tag;
    index_t      req_index;
    offset_t     req_offset;
    logic [1:0]  byte_sel;

    logic        access;
    logic        cpu_phase;
    logic        last_word;

    logic [3:0]  store_be;
    word_t       store_data;
    word_t       lane_word;

    // ========================================
    // request decode
    // ========================================

    assign req_tag    = cpu_req_i.addr[`CACHE_ADDR_BITS-1 -: `CACHE_TAG_BITS];
    assign req_index  = cpu_req_i.addr[`CACHE_INDEX_BITS+`CACHE_OFFSET_BITS+1 -: `CACHE_INDEX_BITS];
    assign req_offset = cpu_req_i.addr[`CACHE_OFFSET_BITS+1 -: `CACHE_OFFSET_BITS];
    assign byte_sel   = cpu_req_i.addr[1:0];

    assign access    = cpu_req_i.read || cpu_req_i.write;
    assign cpu_phase = (state_q == IDLE) || (state_q == WAIT);
    assign last_word = count_q == offset_t'(`CACHE_LINE_WORDS - 1);

    // ========================================
    // miss fsm and word counter
    // ========================================

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
            count_q <= '0;
        end else begin
            state_q <= state_d;
            count_q <= count_d;
        end
    end

    always_comb begin
        state_d = state_q;
        count_d = count_q;
        case (state_q)
            IDLE: begin
                count_d = '0;
                if (access && !hit_i) begin
                    state_d = (valid_i && dirty_i) ? PRE_BACK : FILL;
                end
            end
            PRE_BACK: state_d = BACK;
            BACK, FILL: begin
                // counter and state only move on ack
                if (mem_resp_i.ack) begin
                    count_d = offset_t'(count_q + 1'b1);
                    if (last_word) begin
                        state_d = (state_q == BACK) ? FILL : WAIT;
                    end
                end
            end
            WAIT: begin
                state_d = IDLE;
                count_d = '0;
            end
            default: state_d = IDLE;
        endcase
    end

    // wait completes the access as a hit
    assign stall_o = state_d != IDLE;

    // ========================================
    // store addressing and writes
    // ========================================

    assign index_o      = req_index;
    assign offset_o     = cpu_phase ? req_offset : count_q;
    assign lookup_tag_o = req_tag;

    always_comb begin
        case (cpu_req_i.size[1:0])
            SIZE_BYTE: begin
                store_be   = 4'b0001 << byte_sel;
                store_data = {4{cpu_req_i.wdata[7:0]}};
            end
            SIZE_HALF: begin
                store_be   = byte_sel[1] ? 4'b1100 : 4'b0011;
                store_data = {2{cpu_req_i.wdata[15:0]}};
            end
            default: begin
                store_be   = 4'b1111;
                store_data = cpu_req_i.wdata;
            end
        endcase
    end

    always_comb begin
        wr_o.index  = req_index;
        wr_o.offset = offset_o;
        wr_o.tag    = req_tag;
        wr_o.be     = store_be;
        wr_o.refill = (state_q == FILL) && mem_resp_i.ack;
        wr_o.edit   = cpu_phase && cpu_req_i.write && hit_i;
        wr_o.wdata  = wr_o.refill ? mem_resp_i.rdata : store_data;
    end

    // ========================================
    // memory requests
    // ========================================

    always_comb begin
        mem_req_o = '0;
        case (state_q)
            BACK: begin
                // victim address comes from the stored tag
                mem_req_o.cs    = 1'b1;
                mem_req_o.we    = 1'b1;
                mem_req_o.addr  = {tag_i, req_index, count_q, 2'b00};
                mem_req_o.wdata = word_i;
            end
            FILL: begin
                mem_req_o.cs   = 1'b1;
                mem_req_o.addr = {req_tag, req_index, count_q, 2'b00};
            end
            default: ;
        endcase
    end

    // ========================================
    // load alignment
    // ========================================

    assign lane_word = word_i >> {byte_sel, 3'b000};

    always_comb begin
        case (cpu_req_i.size[1:0])
            SIZE_BYTE: begin
                if (cpu_req_i.size[2]) begin
                    rdata_o = {24'b0, lane_word[7:0]};
                end else begin
                    rdata_o = {{24{lane_word[7]}}, lane_word[7:0]};
                end
            end
            SIZE_HALF: begin
                if (cpu_req_i.size[2]) begin
                    rdata_o = {16'b0, lane_word[15:0]};
                end else begin
                    rdata_o = {{16{lane_word[15]}}, lane_word[15:0]};
                end
            end
            default: rdata_o = word_i;
        endcase
    end

endmodule

// ==== hw/data_cache.sv ====
module data_cache
    import cache_types_pkg::*;
    import cache_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    // cpu load/store port
    input  cpu_req_t  cpu_req_i,
    output word_t     rdata_o,
    output logic      stall_o,

    // memory bus
    output mem_req_t  mem_req_o,
    input  mem_resp_t mem_resp_i
);

    index_t    index;
    offset_t   offset;
    tag_t      lookup_tag;
    tag_t      stored_tag;
    store_wr_t store_wr;
    logic      hit;
    logic      valid;
    logic      dirty;
    word_t     store_word;

    // ========================================
    // stores
    // ========================================

    tag_store u_tag_store (
        .clk     (clk),
        .rst     (rst),
        .index_i (index),
        .tag_i   (lookup_tag),
        .wr_i    (store_wr),
        .valid_o (valid),
        .dirty_o (dirty),
        .tag_o   (stored_tag),
        .hit_o   (hit)
    );

    data_store u_data_store (
        .clk      (clk),
        .index_i  (index),
        .offset_i (offset),
        .wr_i     (store_wr),
        .rdata_o  (store_word)
    );

    // ========================================
    // controller
    // ========================================

    cache_ctrl u_cache_ctrl (
        .clk          (clk),
        .rst          (rst),
        .cpu_req_i    (cpu_req_i),
        .hit_i        (hit),
        .valid_i      (valid),
        .dirty_i      (dirty),
        .tag_i        (stored_tag),
        .word_i       (store_word),
        .mem_resp_i   (mem_resp_i),
        .index_o      (index),
        .offset_o     (offset),
        .lookup_tag_o (lookup_tag),
        .wr_o         (store_wr),
        .mem_req_o    (mem_req_o),
        .rdata_o      (rdata_o),
        .stall_o      (stall_o)
    );

endmodule

// ==== tests/tb_main_memory.sv ====
module tb_main_memory
    import cache_types_pkg::*;
    import cache_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  mem_req_t  mem_req_i,
    output mem_resp_t mem_resp_o,
    output int        wb_count_o
);

    word_t       mem [4096];
    logic [31:0] rng_q;
    logic [1:0]  delay_q;
    logic [11:0] word_idx;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // every word starts as its word address mixed with a marker
    initial begin
        for (int i = 0; i < 4096; i++) begin
            mem[i] = 32'(i) ^ 32'h5a5a_0000;
        end
    end

    assign word_idx = mem_req_i.addr[13:2];

    // ========================================
    // word bus with random ack delay
    // ========================================

    always @(posedge clk) begin
        if (rst) begin
            mem_resp_o <= '0;
            rng_q      <= 32'h6e54_a4db;
            delay_q    <= 2'd0;
            wb_count_o <= 0;
        end else if (mem_resp_o.ack) begin
            // one quiet cycle after each ack, then draw the next delay
            mem_resp_o.ack <= 1'b0;
            rng_q          <= xorshift(rng_q);
            delay_q        <= rng_q[1:0];
        end else if (mem_req_i.cs) begin
            if (delay_q == 2'd0) begin
                mem_resp_o.ack <= 1'b1;
                if (mem_req_i.we) begin
                    mem[word_idx] <= mem_req_i.wdata;
                    wb_count_o    <= wb_count_o + 1;
                end else begin
                    mem_resp_o.rdata <= mem[word_idx];
                end
            end else begin
                delay_q <= delay_q - 2'd1;
            end
        end
    end

endmodule

// ==== tests/tb_data_cache.sv ====
module tb_data_cache
    import cache_types_pkg::*;
    import cache_bus_pkg::*;
();

    localparam logic OP_LOAD  = 1'b0;
    localparam logic OP_STORE = 1'b1;

    localparam access_size_t SZ_B  = 3'b000;
    localparam access_size_t SZ_H  = 3'b001;
    localparam access_size_t SZ_W  = 3'b010;
    localparam access_size_t SZ_BU = 3'b100;
    localparam access_size_t SZ_HU = 3'b101;

    logic      clk;
    logic      rst;
    cpu_req_t  cpu_req;
    word_t     rdata;
    logic      stall;
    mem_req_t  mem_req;
    mem_resp_t mem_resp;
    int        wb_count;
    logic      table_ready;

    // stimulus table with one entry per index
    string        name_q [$];
    logic         op_q [$];
    addr_t        addr_q [$];
    access_size_t size_q [$];
    word_t        wdata_q [$];
    logic         miss_q [$];
    int           wb_q [$];

    // reference copy of memory as the cpu sees it
    word_t shadow [4096];

    data_cache u_dut (
        .clk        (clk),
        .rst        (rst),
        .cpu_req_i  (cpu_req),
        .rdata_o    (rdata),
        .stall_o    (stall),
        .mem_req_o  (mem_req),
        .mem_resp_i (mem_resp)
    );

    tb_main_memory u_mem (
        .clk        (clk),
        .rst        (rst),
        .mem_req_i  (mem_req),
        .mem_resp_o (mem_resp),
        .wb_count_o (wb_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ========================================
    // reference model and checks
    // ========================================

    function automatic word_t shadow_load(input addr_t addr, input access_size_t size);
        word_t       w;
        logic [7:0]  b;
        logic [15:0] h;
        w = shadow[addr[13:2]];
        b = w[{addr[1:0], 3'b000} +: 8];
        h = addr[1] ? w[31:16] : w[15:0];
        case (size[1:0])
            2'd0: return size[2] ? {24'h0, b} : {{24{b[7]}}, b};
            2'd1: return size[2] ? {16'h0, h} : {{16{h[15]}}, h};
            default: return w;
        endcase
    endfunction

    task automatic shadow_store(input addr_t addr, input access_size_t size, input word_t wdata);
        case (size[1:0])
            2'd0: shadow[addr[13:2]][{addr[1:0], 3'b000} +: 8] = wdata[7:0];
            2'd1: begin
                if (addr[1]) begin
                    shadow[addr[13:2]][31:16] = wdata[15:0];
                end else begin
                    shadow[addr[13:2]][15:0] = wdata[15:0];
                end
            end
            default: shadow[addr[13:2]] = wdata;
        endcase
    endtask

    task automatic check_value(input string name, input string what,
                               input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("MISMATCH %s %s expected %h actual %h", name, what, expected, actual);
            $display("Something failed");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic add_entry(input string name, input logic op, input addr_t addr,
                             input access_size_t size, input word_t wdata,
                             input logic miss, input int wb);
        name_q.push_back(name);
        op_q.push_back(op);
        addr_q.push_back(addr);
        size_q.push_back(size);
        wdata_q.push_back(wdata);
        miss_q.push_back(miss);
        wb_q.push_back(wb);
    endtask

    // ========================================
    // stimulus table
    // ========================================

    task automatic build_table();
        add_entry("first_load", OP_LOAD, 32'h0000_0040, SZ_W, 32'h0, 1'b1, 0);
        add_entry("same_line_hit", OP_LOAD, 32'h0000_0044, SZ_W, 32'h0, 1'b0, 0);
        add_entry("line_end_hit", OP_LOAD, 32'h0000_004c, SZ_W, 32'h0, 1'b0, 0);
        add_entry("store_byte", OP_STORE, 32'h0000_0041, SZ_B, 32'h0000_00a5, 1'b0, 0);
        add_entry("load_byte_s", OP_LOAD, 32'h0000_0041, SZ_B, 32'h0, 1'b0, 0);
        add_entry("load_byte_u", OP_LOAD, 32'h0000_0041, SZ_BU, 32'h0, 1'b0, 0);
        add_entry("load_byte_word", OP_LOAD, 32'h0000_0040, SZ_W, 32'h0, 1'b0, 0);
        add_entry("store_half_hi", OP_STORE, 32'h0000_0046, SZ_H, 32'h0000_8123, 1'b0, 0);
        add_entry("load_half_s", OP_LOAD, 32'h0000_0046, SZ_H, 32'h0, 1'b0, 0);
        add_entry("load_half_u", OP_LOAD, 32'h0000_0046, SZ_HU, 32'h0, 1'b0, 0);
        add_entry("load_merged", OP_LOAD, 32'h0000_0044, SZ_W, 32'h0, 1'b0, 0);
        add_entry("load_half_lo", OP_LOAD, 32'h0000_0044, SZ_H, 32'h0, 1'b0, 0);
        // same index with another tag sends the dirty line back first
        add_entry("evict_dirty", OP_LOAD, 32'h0000_0140, SZ_W, 32'h0, 1'b1, 4);
        add_entry("reload_evicted", OP_LOAD, 32'h0000_0041, SZ_BU, 32'h0, 1'b1, 0);
        add_entry("evicted_half", OP_LOAD, 32'h0000_0046, SZ_HU, 32'h0, 1'b0, 0);
        // ping-pong on line 9
        add_entry("alt_store_a", OP_STORE, 32'h0000_0090, SZ_W, 32'hdead_beef, 1'b1, 0);
        add_entry("alt_load_b", OP_LOAD, 32'h0000_0190, SZ_W, 32'h0, 1'b1, 4);
        add_entry("alt_store_b", OP_STORE, 32'h0000_019b, SZ_B, 32'h0000_007e, 1'b0, 0);
        add_entry("alt_load_a", OP_LOAD, 32'h0000_0090, SZ_W, 32'h0, 1'b1, 4);
        add_entry("alt_byte_b", OP_LOAD, 32'h0000_019b, SZ_B, 32'h0, 1'b1, 0);
        add_entry("alt_store_c", OP_STORE, 32'h0000_0292, SZ_H, 32'h0000_beef, 1'b1, 0);
        add_entry("alt_load_a2", OP_LOAD, 32'h0000_0094, SZ_W, 32'h0, 1'b1, 4);
        add_entry("alt_half_c", OP_LOAD, 32'h0000_0292, SZ_H, 32'h0, 1'b1, 0);
        add_entry("alt_word_c", OP_LOAD, 32'h0000_0290, SZ_W, 32'h0, 1'b0, 0);
        // and on line 0
        add_entry("zero_store", OP_STORE, 32'h0000_0000, SZ_W, 32'h1234_5678, 1'b1, 0);
        add_entry("zero_conflict", OP_LOAD, 32'h0000_0100, SZ_W, 32'h0, 1'b1, 4);
        add_entry("zero_reload", OP_LOAD, 32'h0000_0000, SZ_W, 32'h0, 1'b1, 0);
        add_entry("zero_byte_st", OP_STORE, 32'h0000_0103, SZ_B, 32'h0000_0080, 1'b1, 0);
        add_entry("zero_byte_ld", OP_LOAD, 32'h0000_0103, SZ_B, 32'h0, 1'b0, 0);
        add_entry("zero_final", OP_LOAD, 32'h0000_0000, SZ_W, 32'h0, 1'b1, 4);
    endtask

    // drive one entry, wait for stall low, then check it
    task automatic run_entry(input int i);
        cpu_req_t req;
        int       wb_before;
        req       = '0;
        req.read  = op_q[i] == OP_LOAD;
        req.write = op_q[i] == OP_STORE;
        req.addr  = addr_q[i];
        req.size  = size_q[i];
        req.wdata = wdata_q[i];
        wb_before = wb_count;
        @(posedge clk);
        cpu_req <= req;
        @(negedge clk);
        check_value(name_q[i], "miss", {31'd0, miss_q[i]}, {31'd0, stall});
        while (stall) begin
            @(negedge clk);
        end
        if (op_q[i] == OP_LOAD) begin
            check_value(name_q[i], "rdata", shadow_load(addr_q[i], size_q[i]), rdata);
        end else begin
            shadow_store(addr_q[i], size_q[i], wdata_q[i]);
        end
        check_value(name_q[i], "writebacks", 32'(wb_q[i]), 32'(wb_count - wb_before));
    endtask

    // ========================================
    // main sequence and watchdog
    // ========================================

    initial begin
        rst         = 1'b1;
        cpu_req     = '0;
        table_ready = 1'b0;
        for (int i = 0; i < 4096; i++) begin
            shadow[i] = 32'(i) ^ 32'h5a5a_0000;
        end
        build_table();
        table_ready = 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("reset", "stall", 32'd0, {31'd0, stall});
        check_value("reset", "mem_cs", 32'd0, {31'd0, mem_req.cs});
        for (int i = 0; i < name_q.size(); i++) begin
            run_entry(i);
        end
        @(posedge clk);
        cpu_req <= '0;
        @(negedge clk);
        $display("Everything OK");
        $finish;
    end

    initial begin
        int limit;
        wait (table_ready);
        limit = name_q.size() * 40 + 200;
        repeat (limit) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", limit);
        $display("Something failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== sim.f ====
+incdir+hw
hw/cache_types_pkg.sv
hw/cache_bus_pkg.sv
hw/tag_store.sv
hw/data_store.sv
hw/cache_ctrl.sv
hw/data_cache.sv
tests/tb_main_memory.sv
tests/tb_data_cache.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the data cache testbench with verilator

cd "$(dirname "$0")" || exit 1

out=$(verilator --binary --timing -f sim.f --top-module tb_data_cache \
    -o tb_data_cache_sim 2>&1 \
    && ./obj_dir/tb_data_cache_sim 2>&1)
echo "$out"

echo "$out" | grep -qxF "Everything OK" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
